// File: noc_pkg.sv
`default_nettype none

package noc_pkg;

    localparam int PAYLOAD_PTR_W = 12;
    localparam int NOC_FLIT_W = 128;

    typedef logic [3:0] noc_coord_t;
    typedef logic [3:0] noc_fbits_t;
    typedef logic [5:0] flow_id_t;

    // One extra bit above the buffer address tells full from empty
    typedef logic [PAYLOAD_PTR_W:0] payload_ptr_t;

    typedef enum logic [7:0] {
        TCP_TX_MSG_REQ    = 8'h10,
        TCP_TX_ADJUST_PTR = 8'h11,
        TCP_RX_ADJUST_PTR = 8'h12,
        TCP_TX_MSG_NOTIF  = 8'h13
    } noc_msg_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header flit layout

    typedef struct packed {
        logic [2:0]   zero;
        payload_ptr_t ptr;
    } noc_ptr_arg_t;

    // Byte length for TX_REQ, pointer for adjust and notification
    typedef union packed {
        logic [15:0]  length;
        noc_ptr_arg_t ptr_arg;
    } noc_hdr_arg_u;

    typedef struct packed {
        noc_coord_t  dst_x;
        noc_coord_t  dst_y;
        noc_fbits_t  dst_fbits;
        noc_coord_t  src_x;
        noc_coord_t  src_y;
        noc_fbits_t  src_fbits;
        noc_msg_t    msg_type;
        logic [15:0] msg_len;
    } noc_hdr_core_t;

    typedef struct packed {
        noc_hdr_core_t core;
        flow_id_t      flow_id;
        noc_hdr_arg_u  arg;
        logic [NOC_FLIT_W-$bits(noc_hdr_core_t)-$bits(flow_id_t)-17:0] pad;
    } noc_hdr_flit_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partner tiles

    localparam noc_coord_t TCP_TX_TILE_X = 4'd1;
    localparam noc_coord_t TCP_TX_TILE_Y = 4'd0;
    localparam noc_coord_t TCP_RX_TILE_X = 4'd0;
    localparam noc_coord_t TCP_RX_TILE_Y = 4'd1;

    localparam noc_fbits_t TCP_TX_APP_PTR_IF_FBITS = 4'h2;
    localparam noc_fbits_t TCP_RX_APP_PTR_IF_FBITS = 4'h3;
    localparam noc_fbits_t RW_MGR_TX_FBITS         = 4'h5;

endpackage

`default_nettype wire

// File: rw_mgr_pkg.sv
`default_nettype none

package rw_mgr_pkg;

    typedef struct packed {
        noc_pkg::flow_id_t     flow_id;
        noc_pkg::payload_ptr_t rx_offset;
    } rw_cmd_t;

    typedef enum logic [7:0] {
        OK = 8'h00
    } rw_status_e;

    typedef struct packed {
        rw_status_e  status;
        logic [55:0] fill;
    } rw_resp_t;

    typedef struct packed {
        noc_pkg::flow_id_t                   flow_id;
        logic [noc_pkg::PAYLOAD_PTR_W-1:0]   offset;
        rw_resp_t                            data;
    } tx_buf_wr_t;

    localparam int RW_REQ_BYTES  = 16;
    localparam int RW_RESP_BYTES = 8;

    typedef enum logic {
        NOC_SEL_TX_REQ = 1'b0,
        NOC_SEL_ADJUST = 1'b1
    } tx_noc_sel_e;

    typedef enum logic {
        TILE_SEL_RX = 1'b0,
        TILE_SEL_TX = 1'b1
    } tx_tile_sel_e;

endpackage

`default_nettype wire

// File: rw_req_intake.sv
`default_nettype none

module rw_req_intake (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_req,
    output logic                     in_ack,
    input  wire rw_mgr_pkg::rw_cmd_t in_cmd,
    output logic                     push,
    output rw_mgr_pkg::rw_cmd_t      push_cmd,
    input  wire logic                full
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            push <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Hold off the ack while the queue has no room
                    if (in_req && !full) begin
                        state <= ST_ACK;
                        push <= 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!in_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_req && !full) begin
            push_cmd <= in_cmd;
        end
    end

    assign in_ack = (state == ST_ACK);

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        in_req && !in_ack |=> !(in_req && !in_ack) || $stable(in_cmd));

endmodule

`default_nettype wire

// File: rw_cmd_fifo.sv
`default_nettype none

module rw_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                push,
    input  wire rw_mgr_pkg::rw_cmd_t push_cmd,
    output logic                     full,
    input  wire logic                pop,
    output logic                     empty,
    output rw_mgr_pkg::rw_cmd_t      head_cmd
);

    import rw_mgr_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    rw_cmd_t mem [FIFO_DEPTH];

    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_cmd;
        end
    end

    // Same slot, different lap means full
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
                && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign head_cmd = mem[rd_ptr[ADDR_W-1:0]];

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// File: rw_tx_ctrl.sv
`default_nettype none

module rw_tx_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   empty,
    output logic                        pop,
    output logic                        noc_out_req,
    input  wire logic                   noc_out_ack,
    input  wire logic                   noc_in_req,
    output logic                        noc_in_ack,
    input  wire noc_pkg::noc_hdr_flit_t noc_in_flit,
    output logic                        wr_req,
    input  wire logic                   wr_ack,
    output logic                        store_inputs,
    output logic                        store_notif,
    output rw_mgr_pkg::tx_noc_sel_e     noc_sel,
    output rw_mgr_pkg::tx_tile_sel_e    tile_sel
);

    import noc_pkg::*;
    import rw_mgr_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SEND_REQ,
        WAIT_NOTIF,
        WRITE_BUF,
        ADJ_TX,
        ADJ_RX
    } state_e;

    state_e state;
    // 0 while req is up, 1 while waiting for ack to fall
    logic   phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            phase <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!empty) begin
                        state <= SEND_REQ;
                    end
                end
                SEND_REQ: begin
                    if (!phase && noc_out_ack) begin
                        phase <= 1'b1;
                    end else if (phase && !noc_out_ack) begin
                        phase <= 1'b0;
                        state <= WAIT_NOTIF;
                    end
                end
                WAIT_NOTIF: begin
                    if (!phase && noc_in_req) begin
                        phase <= 1'b1;
                    end else if (phase && !noc_in_req) begin
                        phase <= 1'b0;
                        state <= WRITE_BUF;
                    end
                end
                WRITE_BUF: begin
                    if (!phase && wr_ack) begin
                        phase <= 1'b1;
                    end else if (phase && !wr_ack) begin
                        phase <= 1'b0;
                        state <= ADJ_TX;
                    end
                end
                ADJ_TX, ADJ_RX: begin
                    if (!phase && noc_out_ack) begin
                        phase <= 1'b1;
                    end else if (phase && !noc_out_ack) begin
                        phase <= 1'b0;
                        state <= (state == ADJ_TX) ? ADJ_RX : IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                    phase <= 1'b0;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs

    assign pop          = (state == IDLE) && !empty;
    assign store_inputs = pop;
    assign store_notif  = (state == WAIT_NOTIF) && !phase && noc_in_req;

    assign noc_out_req = !phase && (state == SEND_REQ || state == ADJ_TX || state == ADJ_RX);
    assign noc_in_ack  = phase && (state == WAIT_NOTIF);
    assign wr_req      = !phase && (state == WRITE_BUF);

    assign noc_sel  = (state == SEND_REQ) ? NOC_SEL_TX_REQ : NOC_SEL_ADJUST;
    assign tile_sel = (state == ADJ_RX) ? TILE_SEL_RX : TILE_SEL_TX;

    a_notif_type: assert property (@(posedge clk) disable iff (rst)
        store_notif |-> noc_in_flit.core.msg_type == TCP_TX_MSG_NOTIF);

endmodule

`default_nettype wire

// File: rw_tx_datap.sv
`default_nettype none

module rw_tx_datap #(
    parameter int unsigned SRC_X = 0,
    parameter int unsigned SRC_Y = 0
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire rw_mgr_pkg::rw_cmd_t      head_cmd,
    input  wire noc_pkg::noc_hdr_flit_t   noc_in_flit,
    input  wire logic                     store_inputs,
    input  wire logic                     store_notif,
    input  wire rw_mgr_pkg::tx_noc_sel_e  noc_sel,
    input  wire rw_mgr_pkg::tx_tile_sel_e tile_sel,
    output noc_pkg::noc_hdr_flit_t        noc_out_flit,
    output rw_mgr_pkg::tx_buf_wr_t        wr_data
);

    import noc_pkg::*;
    import rw_mgr_pkg::*;

    flow_id_t     flow_id_q;
    payload_ptr_t rx_ptr_q;
    payload_ptr_t tx_ptr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            flow_id_q <= '0;
            rx_ptr_q <= '0;
            tx_ptr_q <= '0;
        end else begin
            if (store_inputs) begin
                flow_id_q <= head_cmd.flow_id;
                rx_ptr_q <= head_cmd.rx_offset;
            end
            if (store_notif) begin
                tx_ptr_q <= noc_in_flit.arg.ptr_arg.ptr;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outgoing flit

    always_comb begin
        noc_out_flit = '0;
        if (noc_sel == NOC_SEL_TX_REQ) begin
            noc_out_flit.core.dst_x     = TCP_TX_TILE_X;
            noc_out_flit.core.dst_y     = TCP_TX_TILE_Y;
            noc_out_flit.core.dst_fbits = TCP_TX_APP_PTR_IF_FBITS;
            noc_out_flit.core.msg_type  = TCP_TX_MSG_REQ;
            noc_out_flit.arg.length     = 16'(RW_RESP_BYTES);
        end else if (tile_sel == TILE_SEL_RX) begin
            noc_out_flit.core.dst_x       = TCP_RX_TILE_X;
            noc_out_flit.core.dst_y       = TCP_RX_TILE_Y;
            noc_out_flit.core.dst_fbits   = TCP_RX_APP_PTR_IF_FBITS;
            noc_out_flit.core.msg_type    = TCP_RX_ADJUST_PTR;
            // Head moves past the consumed request, wrap bit included
            noc_out_flit.arg.ptr_arg.ptr  = rx_ptr_q + payload_ptr_t'(RW_REQ_BYTES);
        end else begin
            noc_out_flit.core.dst_x       = TCP_TX_TILE_X;
            noc_out_flit.core.dst_y       = TCP_TX_TILE_Y;
            noc_out_flit.core.dst_fbits   = TCP_TX_APP_PTR_IF_FBITS;
            noc_out_flit.core.msg_type    = TCP_TX_ADJUST_PTR;
            noc_out_flit.arg.ptr_arg.ptr  = tx_ptr_q + payload_ptr_t'(RW_RESP_BYTES);
        end

        noc_out_flit.core.src_x     = noc_coord_t'(SRC_X);
        noc_out_flit.core.src_y     = noc_coord_t'(SRC_Y);
        noc_out_flit.core.src_fbits = RW_MGR_TX_FBITS;
        noc_out_flit.core.msg_len   = '0;
        noc_out_flit.flow_id        = flow_id_q;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response record for the transmit buffer

    always_comb begin
        wr_data             = '0;
        wr_data.flow_id     = flow_id_q;
        wr_data.offset      = tx_ptr_q[PAYLOAD_PTR_W-1:0];
        wr_data.data.status = OK;
    end

endmodule

`default_nettype wire

// File: rw_mgr_top.sv
`default_nettype none

module rw_mgr_top #(
    parameter int unsigned SRC_X      = 2,
    parameter int unsigned SRC_Y      = 2,
    parameter int          FIFO_DEPTH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_req,
    output logic                        in_ack,
    input  wire rw_mgr_pkg::rw_cmd_t    in_cmd,
    output logic                        noc_out_req,
    input  wire logic                   noc_out_ack,
    output noc_pkg::noc_hdr_flit_t      noc_out_flit,
    input  wire logic                   noc_in_req,
    output logic                        noc_in_ack,
    input  wire noc_pkg::noc_hdr_flit_t noc_in_flit,
    output logic                        wr_req,
    input  wire logic                   wr_ack,
    output rw_mgr_pkg::tx_buf_wr_t      wr_data
);

    import rw_mgr_pkg::*;

    logic         push;
    rw_cmd_t      push_cmd;
    logic         full;
    logic         pop;
    logic         empty;
    rw_cmd_t      head_cmd;
    logic         store_inputs;
    logic         store_notif;
    tx_noc_sel_e  noc_sel;
    tx_tile_sel_e tile_sel;

    rw_req_intake u_intake (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_cmd   (in_cmd),
        .push     (push),
        .push_cmd (push_cmd),
        .full     (full)
    );

    rw_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_cmd (push_cmd),
        .full     (full),
        .pop      (pop),
        .empty    (empty),
        .head_cmd (head_cmd)
    );

    rw_tx_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .pop          (pop),
        .noc_out_req  (noc_out_req),
        .noc_out_ack  (noc_out_ack),
        .noc_in_req   (noc_in_req),
        .noc_in_ack   (noc_in_ack),
        .noc_in_flit  (noc_in_flit),
        .wr_req       (wr_req),
        .wr_ack       (wr_ack),
        .store_inputs (store_inputs),
        .store_notif  (store_notif),
        .noc_sel      (noc_sel),
        .tile_sel     (tile_sel)
    );

    rw_tx_datap #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) u_datap (
        .clk          (clk),
        .rst          (rst),
        .head_cmd     (head_cmd),
        .noc_in_flit  (noc_in_flit),
        .store_inputs (store_inputs),
        .store_notif  (store_notif),
        .noc_sel      (noc_sel),
        .tile_sel     (tile_sel),
        .noc_out_flit (noc_out_flit),
        .wr_data      (wr_data)
    );

endmodule

`default_nettype wire

// File: tb_rw_mgr.sv
`default_nettype none

module tb_rw_mgr;

    import noc_pkg::*;
    import rw_mgr_pkg::*;

    localparam int SRC_X       = 3;
    localparam int SRC_Y       = 2;
    localparam int FIFO_DEPTH  = 4;
    localparam int NUM_CMDS    = 16;
    localparam int CYCLE_LIMIT = NUM_CMDS * 200 + 100;

    logic          clk;
    logic          rst;
    logic          in_req;
    logic          in_ack;
    rw_cmd_t       in_cmd;
    logic          noc_out_req;
    logic          noc_out_ack;
    noc_hdr_flit_t noc_out_flit;
    logic          noc_in_req;
    logic          noc_in_ack;
    noc_hdr_flit_t noc_in_flit;
    logic          wr_req;
    logic          wr_ack;
    tx_buf_wr_t    wr_data;

    // Five words per command, in the column order of the data file
    logic [15:0]  raw_data   [NUM_CMDS * 5];
    flow_id_t     flow_ids   [NUM_CMDS];
    payload_ptr_t rx_offsets [NUM_CMDS];
    payload_ptr_t tails      [NUM_CMDS];
    int           out_delays [NUM_CMDS];
    int           stalls     [NUM_CMDS];

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycle;
    int          acked_cnt;
    int          notif_cnt;
    int          wr_cnt;
    int          done_cnt;
    int          withheld_cycles;

    rw_mgr_top #(
        .SRC_X      (SRC_X),
        .SRC_Y      (SRC_Y),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rw_mgr_top (
        .clk          (clk),
        .rst          (rst),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_cmd       (in_cmd),
        .noc_out_req  (noc_out_req),
        .noc_out_ack  (noc_out_ack),
        .noc_out_flit (noc_out_flit),
        .noc_in_req   (noc_in_req),
        .noc_in_ack   (noc_in_ack),
        .noc_in_flit  (noc_in_flit),
        .wr_req       (wr_req),
        .wr_ack       (wr_ack),
        .wr_data      (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycle = 0;
        while (cycle < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle = cycle + 1;
        end
        $display("Timeout after %0d cycles, %0d of %0d commands finished",
                 cycle, done_cnt, NUM_CMDS);
        $display("RESULT: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and random helpers

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_fault(input string msg);
        errors = errors + 1;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // Two bits, so 0 to 3 cycles
    task automatic draw_jitter(output int cycles);
        cycles = 0;
        repeat (2) begin
            cycles = (cycles << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic noc_hdr_flit_t expected_flit(input int idx, input noc_msg_t kind);
        noc_hdr_flit_t f;
        f = '0;
        f.core.src_x     = noc_coord_t'(SRC_X);
        f.core.src_y     = noc_coord_t'(SRC_Y);
        f.core.src_fbits = RW_MGR_TX_FBITS;
        f.core.msg_type  = kind;
        f.flow_id        = flow_ids[idx];
        case (kind)
            TCP_TX_MSG_REQ: begin
                f.core.dst_x     = TCP_TX_TILE_X;
                f.core.dst_y     = TCP_TX_TILE_Y;
                f.core.dst_fbits = TCP_TX_APP_PTR_IF_FBITS;
                f.arg.length     = 16'(RW_RESP_BYTES);
            end
            TCP_TX_ADJUST_PTR: begin
                f.core.dst_x     = TCP_TX_TILE_X;
                f.core.dst_y     = TCP_TX_TILE_Y;
                f.core.dst_fbits = TCP_TX_APP_PTR_IF_FBITS;
                f.arg.length     = 16'((int'(tails[idx]) + RW_RESP_BYTES) % 8192);
            end
            default: begin
                f.core.dst_x     = TCP_RX_TILE_X;
                f.core.dst_y     = TCP_RX_TILE_Y;
                f.core.dst_fbits = TCP_RX_APP_PTR_IF_FBITS;
                f.arg.length     = 16'((int'(rx_offsets[idx]) + RW_REQ_BYTES) % 8192);
            end
        endcase
        return f;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partner processes

    task automatic drive_requests();
        for (int i = 0; i < NUM_CMDS; i++) begin
            in_cmd.flow_id   = flow_ids[i];
            in_cmd.rx_offset = rx_offsets[i];
            in_req = 1'b1;
            while (!in_ack) @(negedge clk);
            in_req = 1'b0;
            acked_cnt = acked_cnt + 1;
            while (in_ack) @(negedge clk);
        end
    endtask

    task automatic serve_out_flit(input int idx, input noc_msg_t kind);
        noc_hdr_flit_t exp;
        int            jitter;
        while (!noc_out_req) @(negedge clk);
        if (kind == TCP_TX_MSG_REQ && acked_cnt <= idx) begin
            report_fault($sformatf("request flit for command %0d before it was accepted", idx));
        end
        if (kind == TCP_TX_ADJUST_PTR && wr_cnt != idx + 1) begin
            report_fault($sformatf("transmit adjust for command %0d before its buffer write",
                                   idx));
        end
        exp = expected_flit(idx, kind);
        check_value("noc_out_flit.core", 64'(exp.core), 64'(noc_out_flit.core));
        check_value("noc_out_flit.flow_id", 64'(exp.flow_id), 64'(noc_out_flit.flow_id));
        check_value("noc_out_flit.arg", 64'(exp.arg), 64'(noc_out_flit.arg));
        check_value("noc_out_flit.pad", 64'(exp.pad), 64'(noc_out_flit.pad));
        draw_jitter(jitter);
        repeat (out_delays[idx] + jitter) @(negedge clk);
        noc_out_ack = 1'b1;
        while (noc_out_req) @(negedge clk);
        noc_out_ack = 1'b0;
    endtask

    task automatic send_notif(input int idx);
        noc_hdr_flit_t f;
        f = '0;
        f.core.dst_x       = noc_coord_t'(SRC_X);
        f.core.dst_y       = noc_coord_t'(SRC_Y);
        f.core.dst_fbits   = RW_MGR_TX_FBITS;
        f.core.src_x       = TCP_TX_TILE_X;
        f.core.src_y       = TCP_TX_TILE_Y;
        f.core.src_fbits   = TCP_TX_APP_PTR_IF_FBITS;
        f.core.msg_type    = TCP_TX_MSG_NOTIF;
        f.flow_id          = flow_ids[idx];
        f.arg.ptr_arg.ptr  = tails[idx];
        repeat (stalls[idx]) @(negedge clk);
        noc_in_flit = f;
        noc_in_req = 1'b1;
        while (!noc_in_ack) @(negedge clk);
        noc_in_req = 1'b0;
        notif_cnt = notif_cnt + 1;
        while (noc_in_ack) @(negedge clk);
    endtask

    task automatic play_tcp_tiles();
        for (int i = 0; i < NUM_CMDS; i++) begin
            serve_out_flit(i, TCP_TX_MSG_REQ);
            send_notif(i);
            serve_out_flit(i, TCP_TX_ADJUST_PTR);
            serve_out_flit(i, TCP_RX_ADJUST_PTR);
            done_cnt = done_cnt + 1;
        end
    endtask

    task automatic serve_tx_buffer();
        int jitter;
        for (int i = 0; i < NUM_CMDS; i++) begin
            while (!wr_req) @(negedge clk);
            if (notif_cnt != i + 1) begin
                report_fault($sformatf("buffer write for command %0d before its notification", i));
            end
            check_value("wr_data.flow_id", 64'(flow_ids[i]), 64'(wr_data.flow_id));
            check_value("wr_data.offset", 64'(tails[i][PAYLOAD_PTR_W-1:0]),
                        64'(wr_data.offset));
            check_value("wr_data.data", 64'({OK, 56'h0}), 64'(wr_data.data));
            draw_jitter(jitter);
            repeat (jitter) @(negedge clk);
            wr_ack = 1'b1;
            while (wr_req) @(negedge clk);
            wr_ack = 1'b0;
            wr_cnt = wr_cnt + 1;
        end
    endtask

    // Looks one time unit after the falling edge, when both sides have settled
    task automatic watch_queue_limit();
        while (done_cnt < NUM_CMDS) begin
            @(negedge clk);
            #1;
            if (acked_cnt - done_cnt > FIFO_DEPTH + 1) begin
                report_fault("more commands accepted than the queue and controller can hold");
            end
            if (in_req && !in_ack && acked_cnt - done_cnt == FIFO_DEPTH + 1) begin
                withheld_cycles = withheld_cycles + 1;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence

    task automatic run_tests();
        for (int i = 0; i < NUM_CMDS; i++) begin
            flow_ids[i]   = flow_id_t'(raw_data[i * 5]);
            rx_offsets[i] = payload_ptr_t'(raw_data[i * 5 + 1]);
            tails[i]      = payload_ptr_t'(raw_data[i * 5 + 2]);
            out_delays[i] = int'(raw_data[i * 5 + 3]);
            stalls[i]     = int'(raw_data[i * 5 + 4]);
        end
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("in_ack", 64'(1'b0), 64'(in_ack));
        check_value("noc_out_req", 64'(1'b0), 64'(noc_out_req));
        check_value("noc_in_ack", 64'(1'b0), 64'(noc_in_ack));
        check_value("wr_req", 64'(1'b0), 64'(wr_req));
        fork
            drive_requests();
            play_tcp_tiles();
            serve_tx_buffer();
            watch_queue_limit();
        join
        if (withheld_cycles == 0) begin
            report_fault("in_ack was never held back while the queue was full");
        end
        repeat (20) begin
            @(negedge clk);
            if (noc_out_req || wr_req || in_ack || noc_in_ack) begin
                report_fault("handshake activity after the last command");
            end
        end
    endtask

    initial begin : main
        rst             = 1'b1;
        in_req          = 1'b0;
        in_cmd          = '0;
        noc_out_ack     = 1'b0;
        noc_in_req      = 1'b0;
        noc_in_flit     = '0;
        wr_ack          = 1'b0;
        lfsr            = 32'h6044;
        errors          = 0;
        checks          = 0;
        acked_cnt       = 0;
        notif_cnt       = 0;
        wr_cnt          = 0;
        done_cnt        = 0;
        withheld_cycles = 0;
        for (int i = 0; i < NUM_CMDS * 5; i++) begin
            raw_data[i] = 16'hffff;
        end
        $readmemh("rw_mgr_testdata.txt", raw_data);
        if (raw_data[NUM_CMDS * 5 - 1] === 16'hffff) begin
            $display("Test data could not be read from rw_mgr_testdata.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            run_tests();
            $display("Finished after %0d cycles: %0d checks, %0d errors, %0d withheld cycles",
                     cycle, checks, errors, withheld_cycles);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rw_mgr_testdata.txt
// flow_id rx_offset tail_ptr out_ack_delay notif_stall, one command per line, all hex
// Pointers are 13 bits with the wrap bit on top, delay and stall count clock cycles
01 0000 0000 0 2
02 0010 0008 1 0
3f 1ff8 1ffc 2 3
15 0ff0 0ffc 0 1
2a 1234 0abc 3 4
07 0040 0100 1 60
08 0050 0108 0 0
09 1ff0 1ff8 2 1
0a 0060 0110 4 2
0b 0abc 1def 1 0
0c 0070 0118 0 5
0d 1fff 0fff 3 1
0e 0080 0120 1 0
20 0800 1800 2 2
31 0090 0128 0 3
3e 1fe8 1ff4 4 1

// File: verilog.f
noc_pkg.sv
rw_mgr_pkg.sv
rw_req_intake.sv
rw_cmd_fifo.sv
rw_tx_ctrl.sv
rw_tx_datap.sv
rw_mgr_top.sv
tb_rw_mgr.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rw_mgr
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
